//--- hdl/bridge_sequencer.sv
`timescale 1ns/10ps

module bridge_sequencer import wb_bridge_pkg::*; (
   input  logic              sys_clk,
   input  logic              sys_clk_rst,
   input  logic [WORD_W-1:0] in_data_i,          // input FIFO head word
   input  logic              in_empty_i,
   input  logic              out_almost_full_i,
   input  logic              acc_done_i,
   input  logic [WORD_W-1:0] acc_rdata_i,
   input  logic              acc_timed_out_i,
   output logic              in_rd_en_o,
   output logic              out_wr_en_o,
   output logic [WORD_W-1:0] out_data_o,
   output logic              acc_start_o,
   output logic              acc_skip_o,
   output logic              acc_we_o,
   output logic [WORD_W-1:0] acc_adr_o,
   output logic [WORD_W-1:0] acc_wdata_o
);

   localparam int ALIGN_W = $clog2(PACKET_ALIGN);
   // reply position of the last read word in front of address and result
   localparam logic [ALIGN_W-1:0] READ_TAIL = ALIGN_W'(PACKET_ALIGN - 2);

   seq_state_e            state;
   logic [WORD_W-1:0]     command;
   logic [WORD_W-1:0]     address;    // address of the next access
   logic [WORD_W-1:0]     last_adr;   // address of the access that finished last
   logic [WORD_W-1:0]     mask;
   logic [WORD_W-1:0]     rd_word;    // last read data, the old value for read-modify-write
   logic [BLOCK_SIZE_W:0] in_words;   // data words taken from the host
   logic [BLOCK_SIZE_W:0] out_words;  // read words put into the reply
   logic [ALIGN_W-1:0]    in_phase;   // input packet length modulo the alignment
   logic [ALIGN_W-1:0]    out_phase;  // reply length modulo the alignment
   logic                  timeout_flag;

   // ----------------------------------------------------------
   // command decode
   // ----------------------------------------------------------
   cmd_type_e             opcode;
   logic [BLOCK_SIZE_W:0] block_size;
   logic                  block_pos;
   logic [WORD_W-1:0]     addr_step;
   logic                  is_write;
   logic                  is_rmw;
   logic                  take;
   logic                  last_read;
   logic [ALIGN_W-1:0]    out_next;
   logic [WORD_W-1:0]     merged;
   logic [WORD_W-1:0]     result;

   assign opcode     = cmd_type_e'(command[OPCODE_LSB +: OPCODE_W]);
   assign block_size = {1'b0, command[BLOCK_SIZE_LSB +: BLOCK_SIZE_W]};
   assign block_pos  = command[BLOCK_POS_BIT];
   assign addr_step  = {{(WORD_W - ADDR_INCR_W){1'b0}}, command[ADDR_INCR_LSB +: ADDR_INCR_W]};
   assign is_write   = (opcode == cmd_write);
   assign is_rmw     = (opcode == cmd_read_modify_write); // any other code runs as a read

   assign take      = in_rd_en_o && !in_empty_i;         // a word leaves the input FIFO
   assign last_read = (out_words + 1'b1 >= block_size);  // current reply word ends the data
   assign out_next  = out_phase + 1'b1;
   assign merged    = (rd_word & ~mask) | (acc_wdata_o & mask); // masked bits from the host
   assign acc_adr_o = address;

   always_comb begin
      result                     = '0;
      result[RESULT_TIMEOUT_BIT] = timeout_flag;
   end

   // ----------------------------------------------------------
   // packet state machine
   // ----------------------------------------------------------
   always_ff @(posedge sys_clk) begin
      if (sys_clk_rst) begin
         state        <= get_command;
         in_rd_en_o   <= 1'b0;
         out_wr_en_o  <= 1'b0;
         acc_start_o  <= 1'b0;
         in_words     <= '0;
         out_words    <= '0;
         in_phase     <= '0;
         out_phase    <= '0;
         timeout_flag <= 1'b0;
      end else begin
         in_rd_en_o  <= 1'b0; // dropped after every word, one word per two cycles
         out_wr_en_o <= 1'b0;
         acc_start_o <= 1'b0;
         unique case (state)
            get_command: begin
               in_rd_en_o <= !take;
               if (take) begin
                  command   <= in_data_i;
                  in_words  <= '0;
                  out_words <= '0;
                  state     <= get_address;
               end
            end
            get_address: begin
               in_rd_en_o <= !take;
               if (take) begin
                  address <= in_data_i;
                  if (!block_pos) begin
                     timeout_flag <= 1'b0; // a fresh transfer forgets an old timeout
                  end
                  state <= get_mask;
               end
            end
            get_mask: begin
               in_rd_en_o <= !take; // mask slot, a dummy word for everything but rmw
               if (take) begin
                  mask     <= in_data_i;
                  in_phase <= ALIGN_W'(3);
                  state    <= get_data;
               end
            end
            get_data: begin
               if (is_write && in_words >= block_size && in_phase == '0) begin
                  state <= put_command; // data and padding of the burst are consumed
               end else begin
                  in_rd_en_o <= !take;
                  if (take) begin
                     in_phase <= in_phase + 1'b1;
                     // padding words after the burst data are just dropped
                     if (!is_write || in_words < block_size) begin
                        in_words    <= in_words + 1'b1;
                        acc_start_o <= 1'b1;
                        acc_skip_o  <= timeout_flag;
                        acc_we_o    <= is_write;  // rmw starts with the read of the old value
                        acc_wdata_o <= in_data_i;
                        state       <= bus_access;
                     end
                  end
               end
            end
            bus_access: begin
               if (acc_done_i) begin
                  if (acc_timed_out_i) begin
                     timeout_flag <= 1'b1; // sticky over continuation packets
                  end
                  if (!acc_we_o) begin
                     rd_word <= acc_rdata_i;
                  end
                  // the rmw write-back reuses the address of its read
                  if (!is_rmw || acc_we_o) begin
                     last_adr <= address;
                     address  <= address + addr_step;
                  end
                  if (is_write) begin
                     state <= get_data;
                  end else if (acc_we_o || out_words != '0) begin
                     state <= put_data;
                  end else begin
                     state <= put_command; // first read of a packet, reply starts now
                  end
               end
            end
            put_command: begin
               if (!out_almost_full_i) begin
                  out_wr_en_o <= 1'b1;
                  out_data_o  <= command;
                  out_phase   <= ALIGN_W'(1);
                  if (is_rmw) begin
                     acc_start_o <= 1'b1;     // write back the merged word
                     acc_skip_o  <= timeout_flag;
                     acc_we_o    <= 1'b1;
                     acc_wdata_o <= merged;
                     state       <= bus_access;
                  end else begin
                     state <= put_data;
                  end
               end
            end
            put_data: begin
               if (!out_almost_full_i) begin
                  out_wr_en_o <= 1'b1;
                  out_phase   <= out_next;
                  if (is_write) begin
                     out_data_o <= WRITE_FILLER;
                     state      <= put_address;
                  end else if (is_rmw) begin
                     out_data_o <= rd_word; // value before the modification
                     state      <= put_address;
                  end else if (out_words < block_size) begin
                     out_data_o <= rd_word;
                     out_words  <= out_words + 1'b1;
                     if (last_read && out_next == READ_TAIL) begin
                        state <= put_address;
                     end else if (!last_read) begin
                        acc_start_o <= 1'b1; // next read of the burst
                        acc_skip_o  <= timeout_flag;
                        acc_we_o    <= 1'b0;
                        state       <= bus_access;
                     end
                  end else begin
                     out_data_o <= '0;      // zero padding up to the alignment
                     if (out_next == READ_TAIL) begin
                        state <= put_address;
                     end
                  end
               end
            end
            put_address: begin
               if (!out_almost_full_i) begin
                  out_wr_en_o <= 1'b1;
                  out_data_o  <= last_adr;
                  state       <= put_result;
               end
            end
            put_result: begin
               if (!out_almost_full_i) begin
                  out_wr_en_o <= 1'b1;
                  out_data_o  <= result;
                  state       <= get_command;
               end
            end
            default: begin
               state <= get_command;
            end
         endcase
      end
   end

   // input parsing and reply writing never overlap, also across packet boundaries
   a_no_overlap: assert property (@(posedge sys_clk) disable iff (sys_clk_rst)
      in_rd_en_o |-> !out_wr_en_o)
      else $error("bridge_sequencer reads and writes the FIFOs in one cycle");

endmodule

//--- hdl/wb_access.sv
`timescale 1ns/10ps

module wb_access import wb_bridge_pkg::*; #(
   parameter int TIMEOUT_CYCLES = 100
) (
   input  logic              sys_clk,
   input  logic              sys_clk_rst,
   input  logic              start_i,      // one cycle pulse, qualifies the fields below
   input  logic              skip_i,       // finish at once without a bus cycle
   input  logic              we_i,
   input  logic [WORD_W-1:0] adr_i,
   input  logic [WORD_W-1:0] wdata_i,
   input  logic              wb_ack_i,
   input  logic [WORD_W-1:0] wb_dat_i,
   output logic              done_o,       // one cycle pulse at the end of every access
   output logic [WORD_W-1:0] rdata_o,      // zero after a skip or a timeout
   output logic              timed_out_o,
   output logic              wb_cyc_o,
   output logic              wb_stb_o,
   output logic              wb_we_o,
   output logic [WORD_W-1:0] wb_adr_o,
   output logic [WORD_W-1:0] wb_dat_o
);

   localparam int TW = $clog2(TIMEOUT_CYCLES + 1);
   localparam logic [TW-1:0] LAST_TICK = TW'(TIMEOUT_CYCLES - 1);

   logic          cyc_q;  // a bus cycle is open
   logic [TW-1:0] timer;  // cycles spent waiting for ack

   always_ff @(posedge sys_clk) begin
      if (sys_clk_rst) begin
         cyc_q       <= 1'b0;
         timer       <= '0;
         done_o      <= 1'b0;
         timed_out_o <= 1'b0;
      end else begin
         done_o <= 1'b0;
         if (start_i) begin
            cyc_q       <= !skip_i;
            done_o      <= skip_i;   // a skipped access ends in the next cycle
            timed_out_o <= 1'b0;
            timer       <= '0;
         end else if (cyc_q) begin
            if (wb_ack_i) begin
               cyc_q  <= 1'b0;
               done_o <= 1'b1;
            end else if (timer == LAST_TICK) begin
               cyc_q       <= 1'b0;  // the slave gave up, release the bus
               done_o      <= 1'b1;
               timed_out_o <= 1'b1;
            end else begin
               timer <= timer + 1'b1;
            end
         end
      end
   end

   // bus fields are held stable for the whole cycle
   always_ff @(posedge sys_clk) begin
      if (start_i) begin
         wb_we_o  <= we_i;
         wb_adr_o <= adr_i;
         wb_dat_o <= wdata_i;
         rdata_o  <= '0;
      end else if (cyc_q && wb_ack_i) begin
         rdata_o <= wb_dat_i;
      end
   end

   assign wb_cyc_o = cyc_q;
   assign wb_stb_o = cyc_q; // single accesses only, so strobe follows cycle

   // every closing bus cycle ends in a done pulse, with stb dropping together with cyc
   a_close_done: assert property (@(posedge sys_clk) disable iff (sys_clk_rst)
      $fell(wb_cyc_o) |-> (done_o && (wb_stb_o == wb_cyc_o)))
      else $error("wb_access closed a cycle without done");

   // the sequencer waits for done before it launches the next access
   a_start_idle: assert property (@(posedge sys_clk) disable iff (sys_clk_rst)
      start_i |-> (!wb_cyc_o && !done_o))
      else $error("wb_access started while busy");

endmodule

//--- hdl/wb_bridge_pkg.sv
package wb_bridge_pkg;

   localparam int WORD_W = 32; // width of the host stream and of the wishbone data bus

   // ----------------------------------------------------------
   // command word layout
   // ----------------------------------------------------------
   localparam int OPCODE_LSB     = 0;
   localparam int OPCODE_W       = 2;
   localparam int BLOCK_SIZE_LSB = 2;
   localparam int BLOCK_SIZE_W   = 13; // number of data words moved by one packet
   localparam int CMD_ID_LSB     = 15;
   localparam int CMD_ID_W       = 8;  // tag owned by the host, echoed back with the command
   localparam int BLOCK_POS_BIT  = 23; // set on continuation packets of a larger transfer
   localparam int ADDR_INCR_LSB  = 24;
   localparam int ADDR_INCR_W    = 8;  // address step between the accesses of a burst

   // ----------------------------------------------------------
   // reply layout
   // ----------------------------------------------------------
   // a write reply has no bus data, so this word takes its slot
   localparam logic [WORD_W-1:0] WRITE_FILLER = 32'hdeadbeef;
   localparam int PACKET_ALIGN       = 4; // packets in both directions are a multiple of this
   localparam int RESULT_TIMEOUT_BIT = 0; // the only used bit of the result word

   // opcode in the low bits of the command word
   typedef enum logic [1:0] {
      cmd_read              = 2'd0,
      cmd_write             = 2'd1,
      cmd_read_modify_write = 2'd2
   } cmd_type_e;

   // packet sequencer, get states parse the input and put states build the reply
   typedef enum logic [3:0] {
      get_command,
      get_address,
      get_mask,
      get_data,
      bus_access,
      put_command,
      put_data,
      put_address,
      put_result
   } seq_state_e;

endpackage

//--- hdl/wb_bridge_top.sv
`timescale 1ns/10ps

module wb_bridge_top import wb_bridge_pkg::*; #(
   parameter int FIFO_DEPTH     = 256,
   parameter int TIMEOUT_CYCLES = 100
) (
   input  logic              sys_clk,
   input  logic              sys_clk_rst,
   // host input stream
   input  logic              ep_write_i,
   input  logic [WORD_W-1:0] data_i,
   output logic              receive_ready_o,
   // host output stream, data_o follows ep_read_i by one cycle
   input  logic              ep_read_i,
   output logic              send_ready_o,
   output logic [WORD_W-1:0] data_o,
   // wishbone master
   input  logic              wb_ack_i,
   input  logic [WORD_W-1:0] wb_dat_i,
   output logic              wb_cyc_o,
   output logic              wb_stb_o,
   output logic              wb_we_o,
   output logic [WORD_W-1:0] wb_adr_o,
   output logic [WORD_W-1:0] wb_dat_o
);

   // input FIFO to sequencer
   logic [WORD_W-1:0] in_data;
   logic              in_empty;
   logic              in_almost_full;
   logic              in_rd_en;
   // sequencer to output FIFO
   logic              out_wr_en;
   logic [WORD_W-1:0] out_wr_data;
   logic [WORD_W-1:0] out_rd_data;
   logic              out_almost_full;
   logic              out_send_level;
   // sequencer to access unit
   logic              acc_start;
   logic              acc_skip;
   logic              acc_we;
   logic [WORD_W-1:0] acc_adr;
   logic [WORD_W-1:0] acc_wdata;
   logic              acc_done;
   logic [WORD_W-1:0] acc_rdata;
   logic              acc_timed_out;

   word_fifo #(.DEPTH(FIFO_DEPTH)) u_in_fifo (
      .sys_clk(sys_clk), .sys_clk_rst(sys_clk_rst),
      .wr_en_i(ep_write_i), .wr_data_i(data_i), .rd_en_i(in_rd_en),
      .rd_data_o(in_data), .empty_o(in_empty),
      .almost_full_o(in_almost_full), .send_level_o()
   );

   bridge_sequencer u_seq (
      .sys_clk(sys_clk), .sys_clk_rst(sys_clk_rst),
      .in_data_i(in_data), .in_empty_i(in_empty), .out_almost_full_i(out_almost_full),
      .acc_done_i(acc_done), .acc_rdata_i(acc_rdata), .acc_timed_out_i(acc_timed_out),
      .in_rd_en_o(in_rd_en), .out_wr_en_o(out_wr_en), .out_data_o(out_wr_data),
      .acc_start_o(acc_start), .acc_skip_o(acc_skip), .acc_we_o(acc_we),
      .acc_adr_o(acc_adr), .acc_wdata_o(acc_wdata)
   );

   wb_access #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_acc (
      .sys_clk(sys_clk), .sys_clk_rst(sys_clk_rst),
      .start_i(acc_start), .skip_i(acc_skip), .we_i(acc_we),
      .adr_i(acc_adr), .wdata_i(acc_wdata), .wb_ack_i(wb_ack_i), .wb_dat_i(wb_dat_i),
      .done_o(acc_done), .rdata_o(acc_rdata), .timed_out_o(acc_timed_out),
      .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o),
      .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o)
   );

   word_fifo #(.DEPTH(FIFO_DEPTH)) u_out_fifo (
      .sys_clk(sys_clk), .sys_clk_rst(sys_clk_rst),
      .wr_en_i(out_wr_en), .wr_data_i(out_wr_data), .rd_en_i(ep_read_i),
      .rd_data_o(out_rd_data), .empty_o(),
      .almost_full_o(out_almost_full), .send_level_o(out_send_level)
   );

   assign receive_ready_o = !in_almost_full;
   assign send_ready_o    = out_send_level; // a whole aligned chunk is waiting

   // the head word is captured with the read strobe and shown in the next cycle
   always_ff @(posedge sys_clk) begin
      if (ep_read_i) begin
         data_o <= out_rd_data;
      end
   end

endmodule

//--- hdl/word_fifo.sv
`timescale 1ns/10ps

module word_fifo import wb_bridge_pkg::*; #(
   parameter int DEPTH = 256 // power of two
) (
   input  logic              sys_clk,
   input  logic              sys_clk_rst,
   input  logic              wr_en_i,
   input  logic [WORD_W-1:0] wr_data_i,
   input  logic              rd_en_i,        // ignored while empty
   output logic [WORD_W-1:0] rd_data_o,      // head word, valid whenever empty_o is low
   output logic              empty_o,
   output logic              almost_full_o,
   output logic              send_level_o    // at least one aligned packet chunk stored
);

   localparam int AW = $clog2(DEPTH);
   localparam logic [AW:0] FULL_LVL = (AW+1)'(DEPTH);
   localparam logic [AW:0] AF_LVL   = (AW+1)'(DEPTH - 16); // 16 words of slack for late writers
   localparam logic [AW:0] SEND_LVL = (AW+1)'(PACKET_ALIGN);

   logic [WORD_W-1:0] mem [DEPTH];
   logic [AW-1:0]     wr_ptr;
   logic [AW-1:0]     rd_ptr;
   logic [AW:0]       count;   // one bit wider than the pointers so full and empty differ
   logic              rd_fire;

   assign rd_fire = rd_en_i && !empty_o;

   always_ff @(posedge sys_clk) begin
      if (wr_en_i) begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

   // pointers wrap on their own since the depth is a power of two
   always_ff @(posedge sys_clk) begin
      if (sys_clk_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en_i) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_fire) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (wr_en_i && !rd_fire) begin
            count <= count + 1'b1;
         end else if (rd_fire && !wr_en_i) begin
            count <= count - 1'b1; // a simultaneous read and write keeps the level
         end
      end
   end

   assign rd_data_o     = mem[rd_ptr]; // fall-through, no read latency
   assign empty_o       = (count == '0);
   assign almost_full_o = (count >= AF_LVL);
   assign send_level_o  = (count >= SEND_LVL);

   // writers have to respect almost_full_o long before the memory fills up
   a_no_write_full: assert property (@(posedge sys_clk) disable iff (sys_clk_rst)
      (count == FULL_LVL) |-> !wr_en_i)
      else $error("word_fifo written while full");

   // a pop on an empty FIFO would wrap the level below zero and split it from the pointers
   a_no_read_empty: assert property (@(posedge sys_clk) disable iff (sys_clk_rst)
      (count <= FULL_LVL) && (wr_ptr - rd_ptr == count[AW-1:0]))
      else $error("word_fifo level out of step with its pointers");

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 \
   --top-module tb_wb_bridge \
   -f verilog.f \
   -o sim_tb_wb_bridge > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
   cat "$BUILD_LOG"
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb_wb_bridge > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "SIMULATION PASSED" "$SIM_LOG"; then
   exit 0
fi
echo "Pass message not found in $SIM_LOG"
exit 1

//--- tests/tb_wb_bridge.sv
`timescale 1ns/10ps

module tb_wb_bridge import wb_bridge_pkg::*; ();

   localparam int ROWS      = 17;
   localparam int MAXW      = 8;   // longest packet or reply in the table
   localparam int MEM_WORDS = 256;

   logic              sys_clk;
   logic              sys_clk_rst;
   logic              ep_write_i;
   logic [WORD_W-1:0] data_i;
   logic              ep_read_i;
   logic              receive_ready_o;
   logic              send_ready_o;
   logic [WORD_W-1:0] data_o;
   logic              wb_ack;
   logic [WORD_W-1:0] wb_dat_rd;
   logic              wb_cyc;
   logic              wb_stb;
   logic              wb_we;
   logic [WORD_W-1:0] wb_adr;
   logic [WORD_W-1:0] wb_dat_wr;

   logic [WORD_W-1:0] pkt_tab [ROWS][MAXW];
   logic [WORD_W-1:0] exp_tab [ROWS][MAXW];
   int                pkt_len [ROWS];
   int                exp_len [ROWS];
   bit                hold_tab [ROWS];  // reply is left in the output FIFO for now
   bit                nobus_tab [ROWS]; // packet must not open any bus cycle
   int                pending [$];
   int                bus_cycles;
   logic              cyc_seen;

   // a small FIFO so that the held replies really push back on the sequencer
   wb_bridge_top #(.FIFO_DEPTH(32), .TIMEOUT_CYCLES(20)) DUT (
      .sys_clk(sys_clk), .sys_clk_rst(sys_clk_rst),
      .ep_write_i(ep_write_i), .data_i(data_i), .receive_ready_o(receive_ready_o),
      .ep_read_i(ep_read_i), .send_ready_o(send_ready_o), .data_o(data_o),
      .wb_ack_i(wb_ack), .wb_dat_i(wb_dat_rd), .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb),
      .wb_we_o(wb_we), .wb_adr_o(wb_adr), .wb_dat_o(wb_dat_wr)
   );

   wb_slave_model #(.MEM_WORDS(MEM_WORDS), .SEED(32'd99370)) u_slave (
      .sys_clk(sys_clk), .sys_clk_rst(sys_clk_rst),
      .cyc_i(wb_cyc), .stb_i(wb_stb), .we_i(wb_we), .adr_i(wb_adr), .dat_i(wb_dat_wr),
      .ack_o(wb_ack), .dat_o(wb_dat_rd)
   );

   always #50 sys_clk = !sys_clk;

   // counts opened bus cycles so that skipped accesses can be proven silent
   always @(posedge sys_clk) begin
      cyc_seen <= wb_cyc;
      if (wb_cyc && !cyc_seen) begin
         bus_cycles <= bus_cycles + 1;
      end
   end

   // ------------------------------------------------------------
   // compare tasks
   // ------------------------------------------------------------
   task automatic check_word(input string what, input logic [WORD_W-1:0] got,
                             input logic [WORD_W-1:0] expected);
      if (got !== expected) begin
         $display("Fail at %0t: %s, expected %h, got %h", $time, what, expected, got);
         $display("SIMULATION FAILED");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   task automatic check_result(input string what, input logic [WORD_W-1:0] got,
                               input logic [WORD_W-1:0] expected);
      if (got !== expected) begin
         $display("Fail at %0t: %s, result expected %h, got %h (timeout bit %b)",
                  $time, what, expected, got, got[RESULT_TIMEOUT_BIT]);
         $display("SIMULATION FAILED");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   // ------------------------------------------------------------
   // test table
   // ------------------------------------------------------------
   function automatic logic [WORD_W-1:0] cmd_word(input cmd_type_e op, input int size,
                                                  input int id, input logic pos, input int incr);
      logic [WORD_W-1:0] w;
      w          = '0;
      w[1:0]     = op;
      w[14:2]    = 13'(size);
      w[22:15]   = 8'(id);
      w[23]      = pos;    // continuation of the previous packet
      w[31:24]   = 8'(incr);
      return w;
   endfunction

   // four words in and four words out: command, address, mask, data
   task automatic single_row(input int r, input cmd_type_e op, input logic pos,
                             input logic [WORD_W-1:0] adr, input logic [WORD_W-1:0] mask,
                             input logic [WORD_W-1:0] data, input logic [WORD_W-1:0] exp_data,
                             input logic timed_out);
      logic [WORD_W-1:0] c;
      c             = cmd_word(op, 1, r, pos, 1);
      pkt_tab[r][0] = c;
      pkt_tab[r][1] = adr;
      pkt_tab[r][2] = mask;
      pkt_tab[r][3] = data;
      pkt_len[r]    = 4;
      exp_tab[r][0] = c;
      exp_tab[r][1] = exp_data;
      exp_tab[r][2] = adr;
      exp_tab[r][3] = WORD_W'(timed_out);
      exp_len[r]    = 4;
   endtask

   task automatic build_table();
      logic [WORD_W-1:0] c;
      single_row(0, cmd_write, 1'b0, 32'h10, 32'h0, 32'h12345678, WRITE_FILLER, 1'b0);
      single_row(1, cmd_read, 1'b0, 32'h10, 32'h0, 32'h0, 32'h12345678, 1'b0);
      // burst write of five, one dummy after the address and no tail padding
      c = cmd_word(cmd_write, 5, 2, 1'b0, 1);
      pkt_tab[2][0] = c;
      pkt_tab[2][1] = 32'h20;
      pkt_tab[2][2] = 32'h0;
      for (int i = 0; i < 5; i++) begin
         pkt_tab[2][3+i] = 32'ha0000000 + i;
      end
      pkt_len[2] = 8;
      exp_tab[2][0] = c;
      exp_tab[2][1] = WRITE_FILLER;
      exp_tab[2][2] = 32'h24;   // address of the last access
      exp_tab[2][3] = 32'h0;
      exp_len[2] = 4;
      // burst read of five, 1 + 5 + 2 words already fill two chunks
      c = cmd_word(cmd_read, 5, 3, 1'b0, 1);
      pkt_tab[3][0] = c;
      pkt_tab[3][1] = 32'h20;
      pkt_tab[3][2] = 32'h0;
      pkt_tab[3][3] = 32'h0;
      pkt_len[3] = 4;
      exp_tab[3][0] = c;
      for (int i = 0; i < 5; i++) begin
         exp_tab[3][1+i] = 32'ha0000000 + i;
      end
      exp_tab[3][6] = 32'h24;
      exp_tab[3][7] = 32'h0;
      exp_len[3] = 8;
      // rmw replaces the low half, the reply shows the old word
      single_row(4, cmd_read_modify_write, 1'b0, 32'h10, 32'h0000ffff, 32'hcafebeef,
                 32'h12345678, 1'b0);
      single_row(5, cmd_read, 1'b0, 32'h10, 32'h0, 32'h0, 32'h1234beef, 1'b0);
      // dead address, then a continuation that is skipped, then a fresh packet
      single_row(6, cmd_read, 1'b0, 32'h80000040, 32'h0, 32'h0, 32'h0, 1'b1);
      single_row(7, cmd_read, 1'b1, 32'h20, 32'h0, 32'h0, 32'h0, 1'b1);
      nobus_tab[7] = 1'b1;
      single_row(8, cmd_read, 1'b0, 32'h20, 32'h0, 32'h0, 32'ha0000000, 1'b0);
      // eight packets whose replies pile up in the output FIFO
      for (int k = 0; k < 4; k++) begin
         single_row(9 + k, cmd_write, 1'b0, 32'h40 + k, 32'h0, 32'h50000000 + k,
                    WRITE_FILLER, 1'b0);
         single_row(13 + k, cmd_read, 1'b0, 32'h40 + k, 32'h0, 32'h0, 32'h50000000 + k, 1'b0);
      end
      for (int r = 9; r < 16; r++) begin
         hold_tab[r] = 1'b1;
      end
   endtask

   // ------------------------------------------------------------
   // host side drivers, all called right after a falling edge
   // ------------------------------------------------------------
   task automatic send_word(input logic [WORD_W-1:0] w);
      while (!receive_ready_o) @(negedge sys_clk);
      ep_write_i = 1'b1;
      data_i     = w;
      @(negedge sys_clk);
      ep_write_i = 1'b0;
   endtask

   task automatic read_chunk(output logic [WORD_W-1:0] chunk [4]);
      while (!send_ready_o) @(negedge sys_clk);
      for (int i = 0; i < 4; i++) begin
         ep_read_i = 1'b1;
         @(negedge sys_clk);
         ep_read_i = 1'b0;
         chunk[i]  = data_o;   // captured at the rising edge of the read strobe
      end
   endtask

   task automatic drain_reply(input int r);
      logic [WORD_W-1:0] chunk [4];
      int                idx;
      for (int c = 0; c < exp_len[r]; c += 4) begin
         read_chunk(chunk);
         for (int i = 0; i < 4; i++) begin
            idx = c + i;
            if (idx == exp_len[r] - 1) begin
               check_result($sformatf("row %0d result", r), chunk[i], exp_tab[r][idx]);
            end else begin
               check_word($sformatf("row %0d word %0d", r, idx), chunk[i], exp_tab[r][idx]);
            end
         end
      end
   endtask

   // ------------------------------------------------------------
   // main sequence and watchdog
   // ------------------------------------------------------------
   initial begin
      int bus_before;
      int rr;
      sys_clk     = 1'b0;
      sys_clk_rst = 1'b1;
      ep_write_i  = 1'b0;
      data_i      = '0;
      ep_read_i   = 1'b0;
      bus_cycles  = 0;
      build_table();
      repeat (4) @(posedge sys_clk);
      @(negedge sys_clk);
      sys_clk_rst = 1'b0;
      check_word("receive_ready after reset", WORD_W'(receive_ready_o), 32'h1);
      check_word("send_ready after reset", WORD_W'(send_ready_o), 32'h0);
      check_word("wb_cyc after reset", WORD_W'(wb_cyc), 32'h0);
      for (int r = 0; r < ROWS; r++) begin
         bus_before = bus_cycles;
         for (int i = 0; i < pkt_len[r]; i++) begin
            send_word(pkt_tab[r][i]);
         end
         pending.push_back(r);
         if (!hold_tab[r]) begin
            while (pending.size() > 0) begin
               rr = pending.pop_front();
               drain_reply(rr);
            end
            if (nobus_tab[r]) begin
               check_word($sformatf("row %0d bus cycles", r), WORD_W'(bus_cycles),
                          WORD_W'(bus_before));
            end
         end
      end
      $display("SIMULATION PASSED");
      $finish;
   end

   initial begin
      repeat (ROWS * 2000) @(posedge sys_clk);
      $display("Watchdog expired before all replies were checked");
      $display("SIMULATION FAILED");
      $fatal(1, "watchdog");
   end

endmodule

//--- tests/wb_slave_model.sv
`timescale 1ns/10ps

module wb_slave_model import wb_bridge_pkg::*; #(
   parameter int          MEM_WORDS = 256,
   parameter logic [31:0] SEED      = 32'd99370
) (
   input  logic              sys_clk,
   input  logic              sys_clk_rst,
   input  logic              cyc_i,
   input  logic              stb_i,
   input  logic              we_i,
   input  logic [WORD_W-1:0] adr_i,      // word address, bit 31 marks the dead region
   input  logic [WORD_W-1:0] dat_i,
   output logic              ack_o,      // one cycle pulse after a random wait
   output logic [WORD_W-1:0] dat_o
);

   localparam int IW = $clog2(MEM_WORDS);

   logic [WORD_W-1:0] mem [MEM_WORDS];
   logic [31:0]       lfsr;
   logic [31:0]       lfsr_one; // state after one step
   logic [31:0]       lfsr_two; // state after two steps
   logic              busy;     // a request was seen and its wait is running
   logic [1:0]        wait_cnt;

   // fibonacci lfsr with taps 32 22 2 1, the new low bit is the bit taken
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   assign lfsr_one = lfsr_step(lfsr);
   assign lfsr_two = lfsr_step(lfsr_one);

   // every word differs, so a wrong address shows up as wrong data
   initial begin
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = (WORD_W'(i) * 32'h9e3779b9) ^ 32'h0f0f0f0f;
      end
   end

   always @(posedge sys_clk) begin
      if (sys_clk_rst) begin
         ack_o    <= 1'b0;
         busy     <= 1'b0;
         wait_cnt <= '0;
         lfsr     <= SEED;
         dat_o    <= '0;
      end else begin
         ack_o <= 1'b0;
         // the dead region never answers, the master has to time out
         if (cyc_i && stb_i && !ack_o && !adr_i[31]) begin
            if (!busy) begin
               busy     <= 1'b1;
               wait_cnt <= {lfsr_two[0], lfsr_one[0]}; // two bits taken
               lfsr     <= lfsr_two;
            end else if (wait_cnt == 2'd0) begin
               ack_o <= 1'b1;
               busy  <= 1'b0;
               if (we_i) begin
                  mem[adr_i[IW-1:0]] <= dat_i;
               end else begin
                  dat_o <= mem[adr_i[IW-1:0]];
               end
            end else begin
               wait_cnt <= wait_cnt - 1'b1;
            end
         end
      end
   end

endmodule

//--- verilog.f
hdl/wb_bridge_pkg.sv
hdl/word_fifo.sv
hdl/wb_access.sv
hdl/bridge_sequencer.sv
hdl/wb_bridge_top.sv
tests/wb_slave_model.sv
tests/tb_wb_bridge.sv
